// File: csr_file.f
src/csr_pkg.sv
src/csr_write_stage.sv
src/csr_state.sv
src/csr_read_check.sv
src/csr_file.sv
tb/tb_csr_file.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_csr_file
FILELIST = csr_file.f

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: tb/tb_csr_file.sv
/*
  Directed testbench for the supervisor CSR file.
  Covers reset values, deferred commit and flush, exception capture at
  retire, the count register, sret, floating-point state and the
  atomicity check. Outputs are sampled on the falling clock edge.
*/
module tb_csr_file;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  // S, U64 and S64 at reset, and every implemented status bit
  localparam logic [63:0] EXP_STATUS_RESET = 64'h0000_0000_0000_0061;
  localparam logic [63:0] EXP_STATUS_MASK  = 64'h0000_0000_00FF_007F;

  logic                          clk;
  logic                          reset;
  logic                          flush_i;
  csr_pkg::csr_wr_t              wr_req_i;
  logic                          commit_i;
  logic [11:0]                   rd_addr_i;
  logic                          rd_en_i;
  csr_pkg::retire_info_t         retire_i;
  logic [63:0]                   rd_data_o;
  logic                          atomic_vio_o;
  logic [63:0]                   epc_o;
  logic [63:0]                   evec_o;
  logic [63:0]                   status_o;
  logic [2:0]                    frm_o;

  int          errors;
  // count as predicted from the retire reports driven so far
  logic [63:0] exp_count;

  csr_file csr_file_inst (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .wr_req_i     (wr_req_i),
    .commit_i     (commit_i),
    .rd_addr_i    (rd_addr_i),
    .rd_en_i      (rd_en_i),
    .retire_i     (retire_i),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o),
    .epc_o        (epc_o),
    .evec_o       (evec_o),
    .status_o     (status_o),
    .frm_o        (frm_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // watchdog
  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // present an address on the read port and compare once it settles
  task automatic read_expect(input logic [11:0] addr, input logic [63:0] exp, input string msg);
    @(posedge clk);
    rd_addr_i <= addr;
    @(negedge clk);
    check_value(rd_data_o, exp, msg);
  endtask

  // one-cycle execute-stage request strobe
  task automatic request_write(input logic [11:0] addr, input logic [63:0] data);
    csr_pkg::csr_wr_t req;
    req.valid = 1'b1;
    req.addr  = addr;
    req.data  = data;
    @(posedge clk);
    wr_req_i <= req;
    @(posedge clk);
    wr_req_i <= '0;
  endtask

  task automatic pulse_commit();
    @(posedge clk);
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [63:0] data);
    request_write(addr, data);
    pulse_commit();
  endtask

  // one cycle of retire report, then back to idle
  task automatic retire_cycle(input csr_pkg::retire_info_t info);
    @(posedge clk);
    retire_i <= info;
    exp_count = exp_count + 64'(info.total_commit) + 64'(info.exc_valid);
    @(posedge clk);
    retire_i <= '0;
  endtask

  // read with rd_en_i high so the checkpoint is taken
  task automatic checkpoint_read(input logic [11:0] addr);
    @(posedge clk);
    rd_addr_i <= addr;
    rd_en_i   <= 1'b1;
    @(posedge clk);
    rd_en_i   <= 1'b0;
  endtask

  task automatic test_reset_state();
    read_expect(csr_pkg::ADDR_STATUS, EXP_STATUS_RESET, "status after reset");
    check_value(status_o, EXP_STATUS_RESET, "status_o after reset");
    read_expect(csr_pkg::ADDR_EPC, '0, "epc after reset");
    read_expect(csr_pkg::ADDR_CAUSE, '0, "cause after reset");
    read_expect(csr_pkg::ADDR_BADVADDR, '0, "badvaddr after reset");
    read_expect(csr_pkg::ADDR_COUNT, '0, "count after reset");
    read_expect(csr_pkg::ADDR_COMPARE, '0, "compare after reset");
    read_expect(csr_pkg::ADDR_EVEC, '0, "evec after reset");
    read_expect(csr_pkg::ADDR_FCSR, '0, "fcsr after reset");
    // 0x7C0 is not mapped
    read_expect(12'h7C0, '0, "unmapped read");
    check_value(64'(atomic_vio_o), '0, "atomic_vio_o after reset");
    check_value(64'(frm_o), '0, "frm_o after reset");
  endtask

  task automatic test_deferred_commit();
    logic [63:0] d1;
    logic [63:0] d2;
    d1 = {$urandom, $urandom};
    d2 = {$urandom, $urandom};
    request_write(csr_pkg::ADDR_COMPARE, d1);
    read_expect(csr_pkg::ADDR_COMPARE, '0, "compare before commit");
    // state changes only at the edge that ends the commit cycle
    @(posedge clk);
    commit_i <= 1'b1;
    @(negedge clk);
    check_value(rd_data_o, '0, "compare during commit cycle");
    @(posedge clk);
    commit_i <= 1'b0;
    @(negedge clk);
    check_value(rd_data_o, d1 & 64'hFFFF_FFFF, "compare after commit");
    // squashed write
    request_write(csr_pkg::ADDR_COMPARE, d2);
    pulse_flush();
    pulse_commit();
    read_expect(csr_pkg::ADDR_COMPARE, d1 & 64'hFFFF_FFFF, "compare after flushed write");
    pulse_commit();
    read_expect(csr_pkg::ADDR_COMPARE, d1 & 64'hFFFF_FFFF, "compare after idle commit");
    write_csr(csr_pkg::ADDR_STATUS, '1);
    read_expect(csr_pkg::ADDR_STATUS, EXP_STATUS_MASK, "status written with ones");
  endtask

  task automatic test_retire_updates();
    logic [4:0]            causes [0:6];
    csr_pkg::retire_info_t info;
    logic [63:0]           exp_bad;
    causes  = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd6, 5'd7, 5'd2};
    exp_bad = '0;
    for (int i = 0; i < 7; i++)
    begin
      info              = '0;
      info.exc_valid    = 1'b1;
      info.exc_cause    = causes[i];
      info.exc_pc       = {$urandom, $urandom};
      info.ld_addr      = {$urandom, $urandom};
      info.st_addr      = {$urandom, $urandom};
      info.total_commit = 3'($urandom_range(4, 0));
      retire_cycle(info);
      // fetch causes use the pc, loads and stores their own address
      case (causes[i])
        5'd0, 5'd1: exp_bad = info.exc_pc;
        5'd4, 5'd5: exp_bad = info.ld_addr;
        5'd6, 5'd7: exp_bad = info.st_addr;
        default: ;
      endcase
      read_expect(csr_pkg::ADDR_EPC, info.exc_pc, $sformatf("epc, cause %0d", causes[i]));
      check_value(epc_o, info.exc_pc, $sformatf("epc_o, cause %0d", causes[i]));
      read_expect(csr_pkg::ADDR_CAUSE, 64'(causes[i]), $sformatf("cause %0d", causes[i]));
      read_expect(csr_pkg::ADDR_BADVADDR, exp_bad, $sformatf("badvaddr, cause %0d", causes[i]));
      read_expect(csr_pkg::ADDR_COUNT, exp_count, $sformatf("count, cause %0d", causes[i]));
    end
    // count run with a mix of commits and non-memory exceptions
    for (int i = 0; i < 8; i++)
    begin
      info              = '0;
      info.exc_valid    = 1'($urandom);
      info.exc_cause    = 5'd2;
      info.exc_pc       = {$urandom, $urandom};
      info.total_commit = 3'($urandom_range(4, 0));
      retire_cycle(info);
    end
    read_expect(csr_pkg::ADDR_COUNT, exp_count, "count after commit run");
    read_expect(csr_pkg::ADDR_BADVADDR, exp_bad, "badvaddr after cause 2");
  endtask

  task automatic test_sret_and_fp();
    csr_pkg::retire_info_t info;
    logic [4:0]            exp_flags;
    logic [63:0]           d;
    // PS and PEI set, S and EI clear
    write_csr(csr_pkg::ADDR_STATUS, 64'hA);
    read_expect(csr_pkg::ADDR_STATUS, 64'hA, "status before sret");
    info      = '0;
    info.sret = 1'b1;
    retire_cycle(info);
    read_expect(csr_pkg::ADDR_STATUS, 64'hF, "status after sret");
    check_value(status_o, 64'hF, "status_o after sret");
    write_csr(csr_pkg::ADDR_FCSR, '0);
    exp_flags = '0;
    for (int i = 0; i < 4; i++)
    begin
      info        = '0;
      info.fflags = 5'($urandom);
      retire_cycle(info);
      exp_flags = exp_flags | info.fflags;
      read_expect(csr_pkg::ADDR_FFLAGS, 64'(exp_flags), "accumulated fflags");
    end
    d = {$urandom, $urandom};
    // nonzero rounding mode so the write shows over the cleared field
    d[2:0] = 3'($urandom_range(7, 1));
    write_csr(csr_pkg::ADDR_FRM, d);
    read_expect(csr_pkg::ADDR_FCSR, 64'({d[2:0], exp_flags}), "fcsr after frm write");
    read_expect(csr_pkg::ADDR_FRM, 64'(d[2:0]), "frm read");
    check_value(64'(frm_o), 64'(d[2:0]), "frm_o after frm write");
    d = {$urandom, $urandom};
    write_csr(csr_pkg::ADDR_FCSR, d);
    read_expect(csr_pkg::ADDR_FCSR, 64'(d[7:0]), "fcsr after fcsr write");
    read_expect(csr_pkg::ADDR_FFLAGS, 64'(d[4:0]), "fflags after fcsr write");
    check_value(64'(frm_o), 64'(d[7:5]), "frm_o after fcsr write");
  endtask

  task automatic test_atomicity();
    csr_pkg::retire_info_t info;
    logic [63:0]           d;
    d = {$urandom, $urandom};
    write_csr(csr_pkg::ADDR_EVEC, d);
    // drop the held write so later commits are idle
    pulse_flush();
    read_expect(csr_pkg::ADDR_EVEC, d, "evec write");
    check_value(evec_o, d, "evec_o");
    checkpoint_read(csr_pkg::ADDR_COUNT);
    @(negedge clk);
    check_value(64'(atomic_vio_o), '0, "flag right after count checkpoint");
    info              = '0;
    info.total_commit = 3'd3;
    retire_cycle(info);
    @(negedge clk);
    check_value(64'(atomic_vio_o), 64'd1, "flag after count moved");
    pulse_flush();
    @(negedge clk);
    check_value(64'(atomic_vio_o), '0, "flag after flush");
    checkpoint_read(csr_pkg::ADDR_EVEC);
    repeat (4)
    begin
      @(negedge clk);
      check_value(64'(atomic_vio_o), '0, "flag on stable evec");
    end
    // commit retires the checkpoint
    checkpoint_read(csr_pkg::ADDR_COUNT);
    pulse_commit();
    info.total_commit = 3'd2;
    retire_cycle(info);
    @(negedge clk);
    check_value(64'(atomic_vio_o), '0, "flag after commit cleared checkpoint");
    read_expect(csr_pkg::ADDR_COUNT, exp_count, "count after atomicity test");
  endtask

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    flush_i   = 1'b0;
    wr_req_i  = '0;
    commit_i  = 1'b0;
    rd_addr_i = '0;
    rd_en_i   = 1'b0;
    retire_i  = '0;
    errors    = 0;
    exp_count = '0;
    void'($urandom(32'h8c9c_c950));
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_deferred_commit();
    test_retire_updates();
    test_sret_and_fp();
    test_atomicity();
    $display("tests done, %0d errors", errors);
    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src/csr_file.sv
/*
  Supervisor CSR file of the retire stage.
  Connects the write staging register, the architectural state and
  the read/atomicity-check logic. Writes take effect only at commit,
  reads are combinational, and epc, evec, status and the rounding
  mode are exported to the rest of the core.
*/
module csr_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            flush_i,
  input  csr_pkg::csr_wr_t                wr_req_i,
  input  logic                            commit_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]  rd_addr_i,
  input  logic                            rd_en_i,
  input  csr_pkg::retire_info_t           retire_i,
  output logic [csr_pkg::CSR_WIDTH-1:0]   rd_data_o,
  output logic                            atomic_vio_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]   epc_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]   evec_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]   status_o,
  output logic [csr_pkg::FRM_W-1:0]       frm_o
);

  csr_pkg::csr_wr_t   commit_wr;
  csr_pkg::csr_view_t view;

  // holds the execute-stage write until retirement
  csr_write_stage csr_write_stage_inst (
    .clk         (clk),
    .reset       (reset),
    .flush_i     (flush_i),
    .wr_req_i    (wr_req_i),
    .commit_i    (commit_i),
    .commit_wr_o (commit_wr)
  );

  csr_state csr_state_inst (
    .clk         (clk),
    .reset       (reset),
    .commit_wr_i (commit_wr),
    .retire_i    (retire_i),
    .view_o      (view)
  );

  csr_read_check csr_read_check_inst (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .view_i       (view),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

  assign epc_o    = view.epc;
  assign evec_o   = view.evec;
  assign status_o = view.status;
  // rounding mode for the FP units
  assign frm_o    = view.fcsr[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W];

endmodule

// File: src/csr_read_check.sv
/*
  CSR read port and atomicity check.
  Reads are combinational from the register view. A read with rd_en_i
  high is checkpointed, and while that checkpoint is live the value at
  the same address is compared against it. Any difference means the
  CSR instruction did not execute atomically and must be replayed.
*/
module csr_read_check (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            flush_i,
  input  logic                            commit_i,
  input  logic                            rd_en_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]  rd_addr_i,
  input  csr_pkg::csr_view_t              view_i,
  output logic [csr_pkg::CSR_WIDTH-1:0]   rd_data_o,
  output logic                            atomic_vio_o
);

  logic [csr_pkg::CSR_ADDR_W-1:0] chk_addr;
  logic [csr_pkg::CSR_WIDTH-1:0]  chk_data;
  logic                           chk_valid;
  logic [csr_pkg::CSR_WIDTH-1:0]  chk_live;

  // format one CSR for software, shared by the read port and the check
  function automatic logic [csr_pkg::CSR_WIDTH-1:0] read_fmt(
    input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
    input csr_pkg::csr_view_t             v
  );
    logic [csr_pkg::CSR_WIDTH-1:0] val;
    val = '0;
    case (addr)
      csr_pkg::ADDR_FFLAGS:
        val = csr_pkg::CSR_WIDTH'(v.fcsr[csr_pkg::FFLAGS_W-1:0]);
      csr_pkg::ADDR_FRM:
        val = csr_pkg::CSR_WIDTH'(v.fcsr[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W]);
      csr_pkg::ADDR_FCSR:     val = csr_pkg::CSR_WIDTH'(v.fcsr);
      csr_pkg::ADDR_EPC:      val = v.epc;
      csr_pkg::ADDR_BADVADDR: val = v.badvaddr;
      csr_pkg::ADDR_COUNT:    val = v.count;
      csr_pkg::ADDR_COMPARE:  val = v.compare;
      csr_pkg::ADDR_EVEC:     val = v.evec;
      csr_pkg::ADDR_CAUSE:    val = v.cause;
      csr_pkg::ADDR_STATUS:   val = v.status;
      // unmapped reads return zero
      default:                val = '0;
    endcase
    return val;
  endfunction

  assign rd_data_o = read_fmt(rd_addr_i, view_i);

  // checkpoint payload, taken with every enabled read
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr <= rd_addr_i;
      chk_data <= rd_data_o;
    end
  end

  // a new read takes precedence over flush or commit in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chk_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chk_valid <= 1'b1;
    end
    else if (flush_i || commit_i)
    begin
      chk_valid <= 1'b0;
    end
  end

  // live value of the checkpointed CSR
  assign chk_live = read_fmt(chk_addr, view_i);

  assign atomic_vio_o = chk_valid && (chk_live != chk_data);

endmodule

// File: src/csr_state.sv
/*
  Architectural supervisor CSRs.
  A committed write selects one register by address. Retire updates
  land every cycle on the registers that are not being written:
  exception capture of epc, cause and badvaddr, the instruction count,
  the supervisor-return status swap and floating-point flag accumulation.
  The whole state is presented as one view struct.
*/
module csr_state (
  input  logic                  clk,
  input  logic                  reset,
  input  csr_pkg::csr_wr_t      commit_wr_i,
  input  csr_pkg::retire_info_t retire_i,
  output csr_pkg::csr_view_t    view_o
);

  logic [csr_pkg::FCSR_W-1:0]    fcsr;
  logic [csr_pkg::CSR_WIDTH-1:0] epc;
  logic [csr_pkg::CSR_WIDTH-1:0] badvaddr;
  logic [csr_pkg::CSR_WIDTH-1:0] count;
  logic [csr_pkg::CSR_WIDTH-1:0] compare;
  logic [csr_pkg::CSR_WIDTH-1:0] evec;
  logic [csr_pkg::CSR_WIDTH-1:0] cause;
  logic [csr_pkg::CSR_WIDTH-1:0] status;

  logic [csr_pkg::FCSR_W-1:0]    fcsr_next;
  logic [csr_pkg::CSR_WIDTH-1:0] epc_next;
  logic [csr_pkg::CSR_WIDTH-1:0] badvaddr_next;
  logic [csr_pkg::CSR_WIDTH-1:0] count_next;
  logic [csr_pkg::CSR_WIDTH-1:0] compare_next;
  logic [csr_pkg::CSR_WIDTH-1:0] evec_next;
  logic [csr_pkg::CSR_WIDTH-1:0] cause_next;
  logic [csr_pkg::CSR_WIDTH-1:0] status_next;

  // one-hot write strobes decoded from the commit address
  logic wr_fflags;
  logic wr_frm;
  logic wr_fcsr;
  logic wr_epc;
  logic wr_badvaddr;
  logic wr_count;
  logic wr_compare;
  logic wr_evec;
  logic wr_cause;
  logic wr_status;

  logic [csr_pkg::CSR_WIDTH-1:0] wdata;

  assign wdata = commit_wr_i.data;

  always_comb
  begin
    wr_fflags   = 1'b0;
    wr_frm      = 1'b0;
    wr_fcsr     = 1'b0;
    wr_epc      = 1'b0;
    wr_badvaddr = 1'b0;
    wr_count    = 1'b0;
    wr_compare  = 1'b0;
    wr_evec     = 1'b0;
    wr_cause    = 1'b0;
    wr_status   = 1'b0;
    if (commit_wr_i.valid)
    begin
      case (commit_wr_i.addr)
        csr_pkg::ADDR_FFLAGS:   wr_fflags   = 1'b1;
        csr_pkg::ADDR_FRM:      wr_frm      = 1'b1;
        csr_pkg::ADDR_FCSR:     wr_fcsr     = 1'b1;
        csr_pkg::ADDR_EPC:      wr_epc      = 1'b1;
        csr_pkg::ADDR_BADVADDR: wr_badvaddr = 1'b1;
        csr_pkg::ADDR_COUNT:    wr_count    = 1'b1;
        csr_pkg::ADDR_COMPARE:  wr_compare  = 1'b1;
        csr_pkg::ADDR_EVEC:     wr_evec     = 1'b1;
        csr_pkg::ADDR_CAUSE:    wr_cause    = 1'b1;
        csr_pkg::ADDR_STATUS:   wr_status   = 1'b1;
        // unmapped writes are dropped
        default: ;
      endcase
    end
  end

  // fcsr, flags accumulate from retired FP ops unless software writes them
  always_comb
  begin
    fcsr_next = fcsr;
    if (wr_fcsr)
    begin
      fcsr_next = wdata[csr_pkg::FCSR_W-1:0];
    end
    else if (wr_fflags)
    begin
      fcsr_next[csr_pkg::FFLAGS_W-1:0] = wdata[csr_pkg::FFLAGS_W-1:0];
    end
    else
    begin
      fcsr_next[csr_pkg::FFLAGS_W-1:0] = fcsr[csr_pkg::FFLAGS_W-1:0] | retire_i.fflags;
    end
    // rounding mode sits in the upper field
    if (wr_frm)
    begin
      fcsr_next[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W] = wdata[csr_pkg::FRM_W-1:0];
    end
  end

  // exception capture
  always_comb
  begin
    epc_next      = epc;
    cause_next    = cause;
    badvaddr_next = badvaddr;
    if (retire_i.exc_valid)
    begin
      epc_next   = retire_i.exc_pc;
      cause_next = csr_pkg::CSR_WIDTH'(retire_i.exc_cause);
      case (retire_i.exc_cause)
        csr_pkg::CAUSE_MISALIGNED_FETCH,
        csr_pkg::CAUSE_FAULT_FETCH:      badvaddr_next = retire_i.exc_pc;
        csr_pkg::CAUSE_MISALIGNED_LOAD,
        csr_pkg::CAUSE_FAULT_LOAD:       badvaddr_next = retire_i.ld_addr;
        csr_pkg::CAUSE_MISALIGNED_STORE,
        csr_pkg::CAUSE_FAULT_STORE:      badvaddr_next = retire_i.st_addr;
        // other causes carry no faulting address
        default:                         badvaddr_next = badvaddr;
      endcase
    end
    if (wr_epc)
    begin
      epc_next = wdata;
    end
    if (wr_cause)
    begin
      cause_next = wdata;
    end
    if (wr_badvaddr)
    begin
      badvaddr_next = wdata;
    end
  end

  // count, status, compare and evec
  always_comb
  begin
    // an excepting instruction counts as retired too
    count_next = count + csr_pkg::CSR_WIDTH'(retire_i.total_commit)
               + csr_pkg::CSR_WIDTH'(retire_i.exc_valid);
    if (wr_count)
    begin
      count_next = wdata;
    end

    status_next = status;
    if (wr_status)
    begin
      status_next = wdata & csr_pkg::STATUS_MASK;
    end
    else if (retire_i.sret)
    begin
      // return from supervisor, restore mode and interrupt enable
      status_next[csr_pkg::SR_S]  = status[csr_pkg::SR_PS];
      status_next[csr_pkg::SR_EI] = status[csr_pkg::SR_PEI];
    end

    compare_next = wr_compare ? (wdata & csr_pkg::COMPARE_MASK) : compare;
    evec_next    = wr_evec ? wdata : evec;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fcsr     <= '0;
      epc      <= '0;
      badvaddr <= '0;
      count    <= '0;
      compare  <= '0;
      evec     <= '0;
      cause    <= '0;
      status   <= csr_pkg::STATUS_RESET;
    end
    else
    begin
      fcsr     <= fcsr_next;
      epc      <= epc_next;
      badvaddr <= badvaddr_next;
      count    <= count_next;
      compare  <= compare_next;
      evec     <= evec_next;
      cause    <= cause_next;
      status   <= status_next;
    end
  end

  always_comb
  begin
    view_o.fcsr     = fcsr;
    view_o.epc      = epc;
    view_o.badvaddr = badvaddr;
    view_o.count    = count;
    view_o.compare  = compare;
    view_o.evec     = evec;
    view_o.cause    = cause;
    view_o.status   = status;
  end

endmodule

// File: src/csr_write_stage.sv
/*
  Staging register for the single in-flight CSR write.
  The execute stage hands over a write request, which is held here
  until the CSR instruction retires. A flush squashes the held write,
  so only committed CSR instructions ever change architectural state.
*/
module csr_write_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             flush_i,
  input  csr_pkg::csr_wr_t wr_req_i,
  input  logic             commit_i,
  output csr_pkg::csr_wr_t commit_wr_o
);

  logic [csr_pkg::CSR_ADDR_W-1:0] held_addr;
  logic [csr_pkg::CSR_WIDTH-1:0]  held_data;
  logic                           pending;

  // payload capture, a newer request simply overwrites the old one
  always_ff @(posedge clk)
  begin
    if (wr_req_i.valid)
    begin
      held_addr <= wr_req_i.addr;
      held_data <= wr_req_i.data;
    end
  end

  // pending flag
  // a request in the same cycle as a flush wins, the flush is older
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pending <= 1'b0;
    end
    else if (wr_req_i.valid)
    begin
      pending <= 1'b1;
    end
    else if (flush_i)
    begin
      pending <= 1'b0;
    end
  end

  // release the held write in the commit cycle itself
  always_comb
  begin
    commit_wr_o.valid = pending & commit_i;
    commit_wr_o.addr  = held_addr;
    commit_wr_o.data  = held_data;
  end

endmodule

// File: src/csr_pkg.sv
/*
  Shared definitions for the supervisor CSR file of the retire stage.
  Holds the widths, CSR addresses, status bit positions, write masks,
  exception cause codes and the packed structs that travel between
  the write stage, the register state and the read/check logic.
  Every user refers to these by scoped name.
*/
package csr_pkg;

  // datapath widths
  localparam int unsigned CSR_WIDTH  = 64;
  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned SIZE_PC    = 64;
  localparam int unsigned VADDR_W    = 64;
  localparam int unsigned CAUSE_W    = 5;
  // up to four retired instructions per cycle
  localparam int unsigned COMMIT_W   = 3;

  // floating-point control field widths, fflags sits below frm in fcsr
  localparam int unsigned FFLAGS_W = 5;
  localparam int unsigned FRM_W    = 3;
  localparam int unsigned FCSR_W   = FFLAGS_W + FRM_W;

  // CSR address map
  localparam logic [CSR_ADDR_W-1:0] ADDR_FFLAGS   = 12'h001;
  localparam logic [CSR_ADDR_W-1:0] ADDR_FRM      = 12'h002;
  localparam logic [CSR_ADDR_W-1:0] ADDR_FCSR     = 12'h003;
  localparam logic [CSR_ADDR_W-1:0] ADDR_EVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_EPC      = 12'h502;
  localparam logic [CSR_ADDR_W-1:0] ADDR_BADVADDR = 12'h503;
  localparam logic [CSR_ADDR_W-1:0] ADDR_COUNT    = 12'h506;
  localparam logic [CSR_ADDR_W-1:0] ADDR_COMPARE  = 12'h507;
  localparam logic [CSR_ADDR_W-1:0] ADDR_CAUSE    = 12'h509;
  localparam logic [CSR_ADDR_W-1:0] ADDR_STATUS   = 12'h50A;

  // status bit positions
  localparam int unsigned SR_S   = 0;
  localparam int unsigned SR_PS  = 1;
  localparam int unsigned SR_EI  = 2;
  localparam int unsigned SR_PEI = 3;
  localparam int unsigned SR_EF  = 4;
  localparam int unsigned SR_U64 = 5;
  localparam int unsigned SR_S64 = 6;
  // interrupt mask field, bits 23:16
  localparam int unsigned SR_IM_LSB = 16;
  localparam int unsigned SR_IM_W   = 8;

  localparam logic [CSR_WIDTH-1:0] SR_IM_MASK =
    CSR_WIDTH'({SR_IM_W{1'b1}}) << SR_IM_LSB;

  // supervisor mode with both 64-bit modes enabled
  localparam logic [CSR_WIDTH-1:0] STATUS_RESET =
    (CSR_WIDTH'(1) << SR_S) | (CSR_WIDTH'(1) << SR_U64) | (CSR_WIDTH'(1) << SR_S64);

  // only the implemented status bits survive a write
  localparam logic [CSR_WIDTH-1:0] STATUS_MASK =
    (CSR_WIDTH'(1) << SR_S)   | (CSR_WIDTH'(1) << SR_PS)  |
    (CSR_WIDTH'(1) << SR_EI)  | (CSR_WIDTH'(1) << SR_PEI) |
    (CSR_WIDTH'(1) << SR_EF)  | (CSR_WIDTH'(1) << SR_U64) |
    (CSR_WIDTH'(1) << SR_S64) | SR_IM_MASK;

  // compare is a 32-bit register
  localparam logic [CSR_WIDTH-1:0] COMPARE_MASK = 64'h0000_0000_FFFF_FFFF;

  // exception causes that load badvaddr
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_FETCH = 5'd0;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_FETCH      = 5'd1;
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_LOAD  = 5'd4;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_LOAD       = 5'd5;
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_STORE = 5'd6;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_STORE      = 5'd7;

  // one CSR write, either requested by execute or released at commit
  typedef struct packed {
    logic                  valid;
    logic [CSR_ADDR_W-1:0] addr;
    logic [CSR_WIDTH-1:0]  data;
  } csr_wr_t;

  // per-cycle report from retire
  typedef struct packed {
    logic                exc_valid;
    logic [CAUSE_W-1:0]  exc_cause;
    logic [SIZE_PC-1:0]  exc_pc;
    logic [VADDR_W-1:0]  ld_addr;
    logic [VADDR_W-1:0]  st_addr;
    logic [COMMIT_W-1:0] total_commit;
    logic [FFLAGS_W-1:0] fflags;
    logic                sret;
  } retire_info_t;

  // architectural CSR state as seen by readers
  typedef struct packed {
    logic [FCSR_W-1:0]    fcsr;
    logic [CSR_WIDTH-1:0] epc;
    logic [CSR_WIDTH-1:0] badvaddr;
    logic [CSR_WIDTH-1:0] count;
    logic [CSR_WIDTH-1:0] compare;
    logic [CSR_WIDTH-1:0] evec;
    logic [CSR_WIDTH-1:0] cause;
    logic [CSR_WIDTH-1:0] status;
  } csr_view_t;

endpackage
